// File: rtl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit #(
    parameter int XLEN_P   = pipe_pkg::XLEN,
    parameter int REG_AW_P = pipe_pkg::REG_AW
) (
    input  pipe_pkg::issue_t    lane,
    input  logic [XLEN_P-1:0]   rj_val,
    input  logic [XLEN_P-1:0]   rk_val,
    output pipe_pkg::result_t   link,
    output pipe_pkg::redirect_t redirect_next
);
    import isa_pkg::*;

    logic              taken;
    logic              is_link;
    logic [XLEN_P-1:0] target;
    logic [XLEN_P-1:0] seq_pc;

    always_comb begin
        case (lane.uop.cond)
            BR_JIRL, BR_B, BR_BL: taken = 1'b1;
            BR_BEQ:  taken = rj_val == rk_val;
            BR_BNE:  taken = rj_val != rk_val;
            BR_BLT:  taken = $signed(rj_val) < $signed(rk_val);
            BR_BGE:  taken = $signed(rj_val) >= $signed(rk_val);
            BR_BLTU: taken = rj_val < rk_val;
            BR_BGEU: taken = rj_val >= rk_val;
            default: taken = 1'b0;
        endcase
    end

    assign seq_pc = lane.pc + XLEN_P'(4);

    // jirl is register relative, everything else pc relative
    assign target = (lane.uop.cond == BR_JIRL ? rj_val : lane.pc) + lane.imm;

    assign is_link = lane.uop.cond == BR_BL || lane.uop.cond == BR_JIRL;

    always_comb begin
        link.en   = lane.en && is_link;
        // bl always links to r1
        link.rd   = (lane.uop.cond == BR_BL) ? REG_AW_P'(1) : lane.rd;
        link.data = seq_pc;
        link.pc   = lane.pc;
    end

    always_comb begin
        redirect_next.valid      = lane.en;
        redirect_next.taken      = lane.en && taken;
        redirect_next.branch_pc  = lane.pc;
        redirect_next.target     = target;
        redirect_next.correct_pc = taken ? target : seq_pc;
        // wrong direction, or right direction but wrong target
        redirect_next.flush      = lane.en &&
                                   (taken != lane.pred_taken ||
                                    (taken && target != lane.pc_next));
    end

endmodule

// File: rtl/exe_stage.sv
`timescale 1ns/1ns

module exe_stage #(
    parameter int XLEN_P   = pipe_pkg::XLEN,
    parameter int REG_AW_P = pipe_pkg::REG_AW
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_flush,
    input  pipe_pkg::issue_t    lane0_in,
    input  pipe_pkg::issue_t    lane1_in,
    input  logic [XLEN_P-1:0]   rf_rj0,
    input  logic [XLEN_P-1:0]   rf_rk0,
    input  logic [XLEN_P-1:0]   rf_rj1,
    input  logic [XLEN_P-1:0]   rf_rk1,
    output pipe_pkg::result_t   lane0_out,
    output pipe_pkg::result_t   lane1_out,
    output pipe_pkg::redirect_t redirect,
    output logic                stall
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN_P-1:0] src_rj0;
    logic [XLEN_P-1:0] src_rk0;
    logic [XLEN_P-1:0] src_rj1;
    logic [XLEN_P-1:0] src_rk1;
    logic [XLEN_P-1:0] opb0;
    logic [XLEN_P-1:0] opb1;
    logic [XLEN_P-1:0] alu_y0;
    logic [XLEN_P-1:0] alu_y1;
    logic              alu_en0;
    logic              alu_en1;
    logic              br_en;
    logic              mul_en;
    logic              dep0;
    logic              dep1;
    logic              mid_flush;
    issue_t            br_lane;
    result_t           link;
    result_t           mul_res;
    result_t           mid0_d;
    result_t           mid1_d;
    result_t           mid0_q;
    result_t           mid1_q;
    result_t           fin0_d;
    redirect_t         red_next;
    mul_mid_t          mul_mid;

    // unit enables from the unit field
    assign alu_en0 = lane0_in.en && lane0_in.uop.unit == UNIT_ALU;
    assign br_en   = lane0_in.en && lane0_in.uop.unit == UNIT_BR;
    assign mul_en  = lane0_in.en && lane0_in.uop.unit == UNIT_MUL;
    assign alu_en1 = lane1_in.en && lane1_in.uop.unit == UNIT_ALU;

    operand_forward #(.XLEN_P(XLEN_P), .REG_AW_P(REG_AW_P)) u_fwd (
        .rj0     (lane0_in.rj),
        .rk0     (lane0_in.rk),
        .rj1     (lane1_in.rj),
        .rk1     (lane1_in.rk),
        .rf_rj0  (rf_rj0),
        .rf_rk0  (rf_rk0),
        .rf_rj1  (rf_rj1),
        .rf_rk1  (rf_rk1),
        .mid0    (mid0_q),
        .mid1    (mid1_q),
        .fin0    (lane0_out),
        .fin1    (lane1_out),
        .src_rj0 (src_rj0),
        .src_rk0 (src_rk0),
        .src_rj1 (src_rj1),
        .src_rk1 (src_rk1)
    );

    assign opb0 = lane0_in.uop.src2_imm ? lane0_in.imm : src_rk0;
    assign opb1 = lane1_in.uop.src2_imm ? lane1_in.imm : src_rk1;

    int_alu #(.XLEN_P(XLEN_P)) alu_0 (
        .op (lane0_in.uop.alu_op),
        .a  (src_rj0),
        .b  (opb0),
        .y  (alu_y0)
    );

    int_alu #(.XLEN_P(XLEN_P)) alu_1 (
        .op (lane1_in.uop.alu_op),
        .a  (src_rj1),
        .b  (opb1),
        .y  (alu_y1)
    );

    always_comb begin
        br_lane    = lane0_in;
        br_lane.en = br_en;
    end

    branch_unit #(.XLEN_P(XLEN_P), .REG_AW_P(REG_AW_P)) u_br (
        .lane          (br_lane),
        .rj_val        (src_rj0),
        .rk_val        (src_rk0),
        .link          (link),
        .redirect_next (red_next)
    );

    mul_unit u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (mid_flush),
        .start  (mul_en),
        .rd     (lane0_in.rd),
        .ctrl   (lane0_in.uop),
        .a      (src_rj0),
        .b      (src_rk0),
        .mid    (mul_mid),
        .result (mul_res)
    );

    // mul-use hazard against the multiply now in its mid stage
    assign dep0  = lane0_in.en && (mul_mid.rd == lane0_in.rj || mul_mid.rd == lane0_in.rk);
    assign dep1  = lane1_in.en && (mul_mid.rd == lane1_in.rj || mul_mid.rd == lane1_in.rk);
    assign stall = mul_mid.en && mul_mid.rd != '0 && (dep0 || dep1);

    // bubble into mid on stall, drop the pair behind a mispredict
    assign mid_flush = wb_flush || redirect.flush || stall;

    always_comb begin
        mid0_d = link;
        if (alu_en0) begin
            mid0_d.en   = 1'b1;
            mid0_d.rd   = lane0_in.rd;
            mid0_d.data = alu_y0;
        end
        mid0_d.pc = lane0_in.pc;
    end

    assign mid1_d = '{en: alu_en1, rd: lane1_in.rd, data: alu_y1, pc: lane1_in.pc};

    // lane 0 final: multiplier product or the mid-stage result
    always_comb begin
        fin0_d = mid0_q;
        if (mul_res.en) begin
            fin0_d.en   = 1'b1;
            fin0_d.rd   = mul_res.rd;
            fin0_d.data = mul_res.data;
        end
    end

    stage_reg #(.payload_t(result_t)) mid0 (
        .clk (clk), .rst_n (rst_n), .flush (mid_flush), .hold (1'b0),
        .d (mid0_d), .q (mid0_q)
    );

    stage_reg #(.payload_t(result_t)) mid1 (
        .clk (clk), .rst_n (rst_n), .flush (mid_flush), .hold (1'b0),
        .d (mid1_d), .q (mid1_q)
    );

    stage_reg #(.payload_t(result_t)) fin0 (
        .clk (clk), .rst_n (rst_n), .flush (wb_flush), .hold (1'b0),
        .d (fin0_d), .q (lane0_out)
    );

    stage_reg #(.payload_t(result_t)) fin1 (
        .clk (clk), .rst_n (rst_n), .flush (wb_flush), .hold (1'b0),
        .d (mid1_q), .q (lane1_out)
    );

    stage_reg #(.payload_t(redirect_t)) red (
        .clk (clk), .rst_n (rst_n), .flush (mid_flush), .hold (1'b0),
        .d (red_next), .q (redirect)
    );

endmodule

// File: rtl/int_alu.sv
`timescale 1ns/1ns

module int_alu #(
    parameter int XLEN_P = pipe_pkg::XLEN
) (
    input  isa_pkg::alu_op_e    op,
    input  logic [XLEN_P-1:0]   a,
    input  logic [XLEN_P-1:0]   b,
    output logic [XLEN_P-1:0]   y
);
    import isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLT:  y = {{(XLEN_P-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(XLEN_P-1){1'b0}}, a < b};
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_NOR:  y = ~(a | b);
            ALU_SLL:  y = a << shamt;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $signed(a) >>> shamt;
            // immediate already shifted by decode
            ALU_LUI:  y = b;
            default:  y = '0;
        endcase
    end

endmodule

// File: rtl/isa_pkg.sv
package isa_pkg;

    // execution unit select
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_BR  = 2'd1,
        UNIT_MUL = 2'd2
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // branch conditions, jirl first
    typedef enum logic [3:0] {
        BR_JIRL = 4'b0011,
        BR_B    = 4'b0100,
        BR_BL   = 4'b0101,
        BR_BEQ  = 4'b0110,
        BR_BNE  = 4'b0111,
        BR_BLT  = 4'b1000,
        BR_BGE  = 4'b1001,
        BR_BLTU = 4'b1010,
        BR_BGEU = 4'b1011
    } br_cond_e;

    typedef struct packed {
        unit_e    unit;
        alu_op_e  alu_op;
        br_cond_e cond;
        logic     src2_imm;
        logic     mul_high;
        logic     is_signed;
    } uop_t;

endpackage

// File: rtl/mul_unit.sv
`timescale 1ns/1ns

module mul_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  logic                        start,
    input  logic [pipe_pkg::REG_AW-1:0] rd,
    input  isa_pkg::uop_t               ctrl,
    input  logic [pipe_pkg::XLEN-1:0]   a,
    input  logic [pipe_pkg::XLEN-1:0]   b,
    output pipe_pkg::mul_mid_t          mid,
    output pipe_pkg::result_t           result
);
    import pipe_pkg::*;

    localparam int HALF = XLEN / 2;

    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [2*XLEN-1:0] sum;
    logic [2*XLEN-1:0] prod;
    mul_mid_t          mid_d;

    // stage one: magnitudes and four partial products
    assign a_neg = ctrl.is_signed && a[XLEN-1];
    assign b_neg = ctrl.is_signed && b[XLEN-1];
    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    always_comb begin
        mid_d.en       = start;
        mid_d.rd       = rd;
        mid_d.mul_high = ctrl.mul_high;
        mid_d.pp_ll    = a_mag[HALF-1:0] * b_mag[HALF-1:0];
        mid_d.pp_lh    = a_mag[HALF-1:0] * b_mag[XLEN-1:HALF];
        mid_d.pp_hl    = a_mag[XLEN-1:HALF] * b_mag[HALF-1:0];
        mid_d.pp_hh    = a_mag[XLEN-1:HALF] * b_mag[XLEN-1:HALF];
        mid_d.neg      = a_neg ^ b_neg;
    end

    stage_reg #(.payload_t(mul_mid_t)) mid_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .hold  (1'b0),
        .d     (mid_d),
        .q     (mid)
    );

    // stage two: align and add, then restore the sign
    assign sum = {mid.pp_hh, {XLEN{1'b0}}} +
                 {{HALF{1'b0}}, mid.pp_lh, {HALF{1'b0}}} +
                 {{HALF{1'b0}}, mid.pp_hl, {HALF{1'b0}}} +
                 {{XLEN{1'b0}}, mid.pp_ll};
    assign prod = mid.neg ? -sum : sum;

    always_comb begin
        result.en   = mid.en;
        result.rd   = mid.rd;
        result.data = mid.mul_high ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        // pc is taken from lane 0's mid register at the top
        result.pc   = '0;
    end

endmodule

// File: rtl/operand_forward.sv
`timescale 1ns/1ns

module operand_forward #(
    parameter int XLEN_P   = pipe_pkg::XLEN,
    parameter int REG_AW_P = pipe_pkg::REG_AW
) (
    input  logic [REG_AW_P-1:0] rj0,
    input  logic [REG_AW_P-1:0] rk0,
    input  logic [REG_AW_P-1:0] rj1,
    input  logic [REG_AW_P-1:0] rk1,
    input  logic [XLEN_P-1:0]   rf_rj0,
    input  logic [XLEN_P-1:0]   rf_rk0,
    input  logic [XLEN_P-1:0]   rf_rj1,
    input  logic [XLEN_P-1:0]   rf_rk1,
    input  pipe_pkg::result_t   mid0,
    input  pipe_pkg::result_t   mid1,
    input  pipe_pkg::result_t   fin0,
    input  pipe_pkg::result_t   fin1,
    output logic [XLEN_P-1:0]   src_rj0,
    output logic [XLEN_P-1:0]   src_rk0,
    output logic [XLEN_P-1:0]   src_rj1,
    output logic [XLEN_P-1:0]   src_rk1
);
    import pipe_pkg::*;

    function automatic logic hit(input result_t s, input logic [REG_AW_P-1:0] r);
        return s.en && r != '0 && s.rd == r;
    endfunction

    // youngest producer wins, lane 1 before lane 0 within an age
    function automatic logic [XLEN_P-1:0] pick(
        input logic [REG_AW_P-1:0] r,
        input logic [XLEN_P-1:0]   rf_val,
        input result_t             m1,
        input result_t             m0,
        input result_t             f1,
        input result_t             f0
    );
        if (hit(m1, r)) return m1.data;
        if (hit(m0, r)) return m0.data;
        if (hit(f1, r)) return f1.data;
        if (hit(f0, r)) return f0.data;
        return rf_val;
    endfunction

    always_comb begin
        src_rj0 = pick(rj0, rf_rj0, mid1, mid0, fin1, fin0);
        src_rk0 = pick(rk0, rf_rk0, mid1, mid0, fin1, fin0);
        src_rj1 = pick(rj1, rf_rj1, mid1, mid0, fin1, fin0);
        src_rk1 = pick(rk1, rf_rk1, mid1, mid0, fin1, fin0);
    end

endmodule

// File: rtl/pipe_pkg.sv
package pipe_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // one lane as it leaves issue
    typedef struct packed {
        logic              en;
        isa_pkg::uop_t     uop;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rk;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   pc_next;
        logic              pred_taken;
    } issue_t;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        logic [XLEN-1:0]   pc;
    } result_t;

    // partial products of the magnitudes, negate flag applied in stage two
    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] rd;
        logic              mul_high;
        logic [XLEN-1:0]   pp_ll;
        logic [XLEN-1:0]   pp_lh;
        logic [XLEN-1:0]   pp_hl;
        logic [XLEN-1:0]   pp_hh;
        logic              neg;
    } mul_mid_t;

    typedef struct packed {
        logic            flush;
        logic [XLEN-1:0] branch_pc;
        logic [XLEN-1:0] target;
        // where fetch should continue
        logic [XLEN-1:0] correct_pc;
        logic            taken;
        logic            valid;
    } redirect_t;

endpackage

// File: rtl/stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     hold,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            // flushed slot becomes a bubble
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: src.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_reg.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/mul_unit.sv
rtl/operand_forward.sv
rtl/exe_stage.sv
test/tb_clock.sv
test/exe_stage_properties.sv
test/exe_stage_tb.sv

// File: test/exe_stage_properties.sv
`timescale 1ns/1ns

module exe_stage_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                wb_flush,
    input logic                stall,
    input pipe_pkg::issue_t    lane0_in,
    input pipe_pkg::result_t   lane0_out,
    input pipe_pkg::result_t   lane1_out,
    input pipe_pkg::result_t   mid0_q,
    input pipe_pkg::result_t   mid1_q,
    input pipe_pkg::redirect_t redirect
);
    import isa_pkg::*;

    int fail_count = 0;

    // everything quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !lane0_out.en && !lane1_out.en && !stall &&
                   !redirect.flush && !redirect.valid)
    else begin
        fail_count++;
        $error("result, stall or redirect active during reset");
    end

    // pair behind a mispredict never reaches writeback
    a_mispredict_drop: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.flush |=> !mid0_q.en && !mid1_q.en ##1 !lane0_out.en && !lane1_out.en)
    else begin
        fail_count++;
        $error("pair behind a mispredicted branch produced a result");
    end

    a_wb_flush_drop: assert property (@(posedge clk) disable iff (!rst_n)
        wb_flush |=> !lane0_out.en && !lane1_out.en && !mid0_q.en && !mid1_q.en
                     ##1 !lane0_out.en && !lane1_out.en)
    else begin
        fail_count++;
        $error("pair in flight survived a writeback flush");
    end

    // only behind a multiply accepted in lane 0 the cycle before
    a_stall_needs_mul: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> $past(lane0_in.en && lane0_in.uop.unit == UNIT_MUL &&
                        !stall && !wb_flush && !redirect.flush))
    else begin
        fail_count++;
        $error("stall raised with no multiply in the mid stage");
    end

endmodule

bind exe_stage exe_stage_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_flush  (wb_flush),
    .stall     (stall),
    .lane0_in  (lane0_in),
    .lane0_out (lane0_out),
    .lane1_out (lane1_out),
    .mid0_q    (mid0_q),
    .mid1_q    (mid1_q),
    .redirect  (redirect)
);

// File: test/exe_stage_tb.sv
`timescale 1ns/1ns

module exe_stage_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int SCRIPT_CYCLES = 360;
    localparam int TIMEOUT       = 2 * SCRIPT_CYCLES + 50;
    localparam int DEPTH         = 1024;

    logic        clk;
    logic        rst_n;
    logic        wb_flush;
    issue_t      lane0_in;
    issue_t      lane1_in;
    logic [31:0] rf_rj0;
    logic [31:0] rf_rk0;
    logic [31:0] rf_rj1;
    logic [31:0] rf_rk1;
    result_t     lane0_out;
    result_t     lane1_out;
    redirect_t   redirect;
    logic        stall;

    // arch holds issued state, rf_file holds committed state
    logic [31:0] arch [32];
    logic [31:0] rf_file [32];
    result_t     exp0 [DEPTH];
    result_t     exp1 [DEPTH];
    redirect_t   expr [DEPTH];
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] lfsr = 32'd76196;
    logic [31:0] pc_cur = 32'h0000_1000;
    logic        prev_mul = 1'b0;
    logic [4:0]  prev_mul_rd = '0;
    logic        pend_flush = 1'b0;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(10)) u_clk (.clk(clk), .rst_n(rst_n));

    exe_stage dut0 (
        .clk (clk), .rst_n (rst_n), .wb_flush (wb_flush),
        .lane0_in (lane0_in), .lane1_in (lane1_in),
        .rf_rj0 (rf_rj0), .rf_rk0 (rf_rk0), .rf_rj1 (rf_rj1), .rf_rk1 (rf_rk1),
        .lane0_out (lane0_out), .lane1_out (lane1_out),
        .redirect (redirect), .stall (stall)
    );

    assign rf_rj0 = rf_file[lane0_in.rj];
    assign rf_rk0 = rf_file[lane0_in.rk];
    assign rf_rj1 = rf_file[lane1_in.rj];
    assign rf_rk1 = rf_file[lane1_in.rk];

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] rd_reg(input logic [4:0] r);
        return (r == 5'd0) ? 32'd0 : arch[r];
    endfunction

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ALU_LUI:  return b;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mul_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic sgn, input logic high);
        logic [63:0] p;
        if (sgn) begin
            p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        end else begin
            p = {32'd0, a} * {32'd0, b};
        end
        return high ? p[63:32] : p[31:0];
    endfunction

    function automatic issue_t make_op(input unit_e u, input alu_op_e op, input br_cond_e cond,
                                       input logic [4:0] rd, input logic [4:0] rj,
                                       input logic [4:0] rk, input logic [31:0] imm,
                                       input logic s2i, input logic high, input logic sgn);
        issue_t l;
        l = '0;
        l.en = 1'b1;
        l.uop = '{unit: u, alu_op: op, cond: cond, src2_imm: s2i, mul_high: high,
                  is_signed: sgn};
        l.rd = rd;
        l.rj = rj;
        l.rk = rk;
        l.imm = imm;
        return l;
    endfunction

    function automatic issue_t rand_alu();
        alu_op_e op;
        op = alu_op_e'(4'(rand_bits(4) % 12));
        return make_op(UNIT_ALU, op, BR_B, 5'(rand_bits(5)), 5'(rand_bits(5)),
                       5'(rand_bits(5)), rand_bits(32), rand_bits(1) != 0, 1'b0, 1'b0);
    endfunction

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR %0t: %s", $time, what);
        end
    endtask

    task automatic compare_result(input result_t got, input result_t exp, input string lane);
        if (exp.en) begin
            expect_true(got.en && got.rd == exp.rd && got.data == exp.data && got.pc == exp.pc,
                        $sformatf("%s got en=%0b rd=%0d data=%h pc=%h, expected rd=%0d data=%h pc=%h",
                                  lane, got.en, got.rd, got.data, got.pc,
                                  exp.rd, exp.data, exp.pc));
        end else begin
            expect_true(!got.en, $sformatf("%s unexpected result rd=%0d", lane, got.rd));
        end
    endtask

    // writeback side: compare, then commit into the register file
    always @(negedge clk) begin : writeback_check
        int k;
        k = cyc % DEPTH;
        if (rst_n) begin
            compare_result(lane0_out, exp0[k], "lane0");
            compare_result(lane1_out, exp1[k], "lane1");
            if (expr[k].valid) begin
                expect_true(redirect == expr[k],
                            $sformatf("redirect got %h, expected %h", redirect, expr[k]));
            end else begin
                expect_true(!redirect.valid, "unexpected redirect.valid");
            end
            if (exp0[k].en && exp0[k].rd != 0) rf_file[exp0[k].rd] = exp0[k].data;
            if (exp1[k].en && exp1[k].rd != 0) rf_file[exp1[k].rd] = exp1[k].data;
            exp0[k] = '0;
            exp1[k] = '0;
            expr[k] = '0;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // reference model for one accepted pair, results due at cycle c+2
    task automatic execute_pair(input issue_t l0, input issue_t l1, input int c);
        result_t     r0;
        result_t     r1;
        redirect_t   rr;
        logic [31:0] a;
        logic [31:0] b;
        logic        tk;
        r0 = '0;
        r1 = '0;
        a = rd_reg(l0.rj);
        b = rd_reg(l0.rk);
        if (l0.en && l0.uop.unit == UNIT_ALU) begin
            r0 = '{en: 1'b1, rd: l0.rd, pc: l0.pc,
                   data: alu_model(l0.uop.alu_op, a, l0.uop.src2_imm ? l0.imm : b)};
        end else if (l0.en && l0.uop.unit == UNIT_MUL) begin
            r0 = '{en: 1'b1, rd: l0.rd, pc: l0.pc,
                   data: mul_model(a, b, l0.uop.is_signed, l0.uop.mul_high)};
            prev_mul = 1'b1;
            prev_mul_rd = l0.rd;
        end else if (l0.en && l0.uop.unit == UNIT_BR) begin
            case (l0.uop.cond)
                BR_BEQ:  tk = a == b;
                BR_BNE:  tk = a != b;
                BR_BLT:  tk = $signed(a) < $signed(b);
                BR_BGE:  tk = $signed(a) >= $signed(b);
                BR_BLTU: tk = a < b;
                BR_BGEU: tk = a >= b;
                default: tk = 1'b1;
            endcase
            rr.valid = 1'b1;
            rr.taken = tk;
            rr.branch_pc = l0.pc;
            rr.target = ((l0.uop.cond == BR_JIRL) ? a : l0.pc) + l0.imm;
            rr.correct_pc = tk ? rr.target : l0.pc + 32'd4;
            rr.flush = (tk != l0.pred_taken) || (tk && rr.target != l0.pc_next);
            expr[(c + 1) % DEPTH] = rr;
            pend_flush = rr.flush;
            if (l0.uop.cond == BR_BL || l0.uop.cond == BR_JIRL) begin
                r0 = '{en: 1'b1, rd: (l0.uop.cond == BR_BL) ? 5'd1 : l0.rd,
                       data: l0.pc + 32'd4, pc: l0.pc};
            end
        end
        if (l1.en && l1.uop.unit == UNIT_ALU) begin
            r1 = '{en: 1'b1, rd: l1.rd, pc: l1.pc,
                   data: alu_model(l1.uop.alu_op, rd_reg(l1.rj),
                                   l1.uop.src2_imm ? l1.imm : rd_reg(l1.rk))};
        end
        if (r0.en && r0.rd != 0) arch[r0.rd] = r0.data;
        if (r1.en && r1.rd != 0) arch[r1.rd] = r1.data;
        exp0[(c + 2) % DEPTH] = r0;
        exp1[(c + 2) % DEPTH] = r1;
    endtask

    task automatic run_pair(input issue_t l0_in, input issue_t l1_in, input logic flush_in);
        issue_t l0;
        issue_t l1;
        logic   exp_stall;
        logic   drop;
        int     c;
        l0 = l0_in;
        l1 = l1_in;
        l0.pc = pc_cur;
        l1.pc = pc_cur + 32'd4;
        pc_cur = pc_cur + 32'd8;
        exp_stall = prev_mul && prev_mul_rd != 0 &&
                    ((l0.en && (l0.rj == prev_mul_rd || l0.rk == prev_mul_rd)) ||
                     (l1.en && (l1.rj == prev_mul_rd || l1.rk == prev_mul_rd)));
        drop = pend_flush || flush_in;
        @(posedge clk);
        #2;
        lane0_in = l0;
        lane1_in = l1;
        wb_flush = flush_in;
        @(negedge clk);
        expect_true(stall == exp_stall, $sformatf("stall is %0b, expected %0b", stall, exp_stall));
        expect_true(redirect.flush == pend_flush, "redirect.flush does not match the model");
        if (exp_stall) begin
            @(negedge clk);
            expect_true(!stall, "stall held for more than one cycle");
        end
        c = cyc;
        prev_mul = 1'b0;
        pend_flush = 1'b0;
        if (flush_in) begin
            exp0[(c + 1) % DEPTH] = '0;
            exp1[(c + 1) % DEPTH] = '0;
            expr[(c + 1) % DEPTH] = '0;
            #1;
            for (int i = 0; i < 32; i++) arch[i] = rf_file[i];
        end
        if (!drop) execute_pair(l0, l1, c);
    endtask

    // lane 1 must not read what lane 0 of the same pair writes
    task automatic run_with_random_lane1(input issue_t l0);
        issue_t     l1;
        logic [4:0] d0;
        l1 = rand_alu();
        d0 = (l0.uop.unit == UNIT_BR && l0.uop.cond == BR_BL) ? 5'd1 : l0.rd;
        if (l1.rj == d0) l1.rj = 5'd0;
        if (l1.rk == d0) l1.rk = 5'd0;
        run_pair(l0, l1, 1'b0);
    endtask

    initial begin : script
        br_cond_e    conds [9];
        logic [31:0] corner [4];
        issue_t      l0;
        logic [4:0]  rj;
        logic [31:0] tgt;
        conds = '{BR_JIRL, BR_B, BR_BL, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        corner = '{32'h8000_0000, 32'hffff_ffff, 32'd0, 32'd7};
        lane0_in = '0;
        lane1_in = '0;
        wb_flush = 1'b0;
        arch[0] = '0;
        rf_file[0] = '0;
        for (int i = 1; i < 32; i++) begin
            arch[i] = rand_bits(32);
            rf_file[i] = arch[i];
        end
        @(posedge rst_n);

        for (int i = 0; i < 40; i++) run_with_random_lane1(rand_alu());

        // forwarding chain at distances one and two, r0 stays zero
        run_pair(make_op(UNIT_ALU, ALU_ADD, BR_B, 5, 1, 2, 0, 0, 0, 0),
                 make_op(UNIT_ALU, ALU_SUB, BR_B, 6, 3, 4, 0, 0, 0, 0), 1'b0);
        run_pair(make_op(UNIT_ALU, ALU_XOR, BR_B, 7, 5, 6, 0, 0, 0, 0),
                 make_op(UNIT_ALU, ALU_OR, BR_B, 8, 6, 5, 0, 0, 0, 0), 1'b0);
        run_pair(make_op(UNIT_ALU, ALU_ADD, BR_B, 9, 5, 0, 0, 0, 0, 0),
                 make_op(UNIT_ALU, ALU_AND, BR_B, 10, 6, 6, 0, 0, 0, 0), 1'b0);
        run_pair(make_op(UNIT_ALU, ALU_ADD, BR_B, 0, 1, 2, 0, 0, 0, 0), '0, 1'b0);
        run_pair('0, make_op(UNIT_ALU, ALU_OR, BR_B, 11, 0, 0, 0, 0, 0, 0), 1'b0);

        for (int ci = 0; ci < 9; ci++) begin
            for (int v = 0; v < 6; v++) begin
                rj = 5'(rand_bits(5));
                l0 = make_op(UNIT_BR, ALU_ADD, conds[ci], 5'(2 + rand_bits(3)), rj,
                             (v >= 3) ? rj : 5'(rand_bits(5)), rand_bits(12) << 2, 0, 0, 0);
                tgt = ((conds[ci] == BR_JIRL) ? rd_reg(rj) : pc_cur) + l0.imm;
                l0.pred_taken = (v % 3) != 0;
                l0.pc_next = (v % 3 == 0) ? pc_cur + 32'd4 :
                             (v % 3 == 1) ? tgt : tgt + 32'd8;
                run_with_random_lane1(l0);
                run_with_random_lane1(rand_alu());
            end
        end

        // corner multiplies, operands loaded one cycle before
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                run_pair(make_op(UNIT_ALU, ALU_LUI, BR_B, 10, 0, 0, corner[i], 1, 0, 0),
                         make_op(UNIT_ALU, ALU_LUI, BR_B, 11, 0, 0, corner[j], 1, 0, 0),
                         1'b0);
                for (int m = 0; m < 4; m++) begin
                    run_pair(make_op(UNIT_MUL, ALU_ADD, BR_B, 12, 10, 11, 0, 0, m[0], m[1]),
                             '0, 1'b0);
                end
            end
        end

        for (int i = 0; i < 16; i++) begin
            run_with_random_lane1(make_op(UNIT_MUL, ALU_ADD, BR_B, 5'(rand_bits(5)),
                                          5'(rand_bits(5)), 5'(rand_bits(5)), 0, 0,
                                          rand_bits(1) != 0, rand_bits(1) != 0));
            run_with_random_lane1(rand_alu());
        end

        // mul-use in lane 0, then in lane 1
        run_pair(make_op(UNIT_MUL, ALU_ADD, BR_B, 13, 1, 2, 0, 0, 0, 1), '0, 1'b0);
        run_pair(make_op(UNIT_ALU, ALU_ADD, BR_B, 14, 13, 1, 0, 0, 0, 0),
                 make_op(UNIT_ALU, ALU_XOR, BR_B, 15, 3, 4, 0, 0, 0, 0), 1'b0);
        run_pair(make_op(UNIT_MUL, ALU_ADD, BR_B, 13, 3, 4, 0, 0, 1, 0), '0, 1'b0);
        run_pair(make_op(UNIT_ALU, ALU_SUB, BR_B, 16, 2, 1, 0, 0, 0, 0),
                 make_op(UNIT_ALU, ALU_ADD, BR_B, 17, 13, 13, 0, 0, 0, 0), 1'b0);

        // writeback flush with two pairs in flight
        run_pair(make_op(UNIT_ALU, ALU_ADD, BR_B, 16, 1, 2, 0, 0, 0, 0), '0, 1'b0);
        run_pair(make_op(UNIT_ALU, ALU_SUB, BR_B, 17, 3, 4, 0, 0, 0, 0),
                 make_op(UNIT_ALU, ALU_OR, BR_B, 19, 5, 6, 0, 0, 0, 0), 1'b0);
        run_pair(make_op(UNIT_ALU, ALU_XOR, BR_B, 18, 1, 3, 0, 0, 0, 0),
                 make_op(UNIT_ALU, ALU_AND, BR_B, 20, 2, 4, 0, 0, 0, 0), 1'b1);
        run_pair(make_op(UNIT_ALU, ALU_ADD, BR_B, 21, 16, 17, 0, 0, 0, 0),
                 make_op(UNIT_ALU, ALU_ADD, BR_B, 22, 18, 19, 0, 0, 0, 0), 1'b0);

        for (int i = 0; i < 4; i++) run_pair('0, '0, 1'b0);
        @(negedge clk);

        $display("checks=%0d errors=%0d assertion_failures=%0d",
                 checks, errors, dut0.u_props.fail_count);
        if (errors == 0 && dut0.u_props.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule
